/* design/switch_consts.svh */
`ifndef SWITCH_CONSTS_SVH
`define SWITCH_CONSTS_SVH

// Number of switch ports
`define SW_NETH		4

// Bits in one MAC address
`define SW_MACW		48

// Bits per stream beat
// Head beat carries dst MAC on top, then src MAC
`define SW_PKTDW	128

// Log2 of routing table entries
`define SW_LGTBL	3

`endif

/* design/switch_pkg.sv */
`default_nettype none
`include "switch_consts.svh"

package switch_pkg;

	// One MAC address
	typedef logic [`SW_MACW-1:0]		mac_t;

	// One bit per switch port, a destination set
	typedef logic [`SW_NETH-1:0]		port_mask_t;

	// Port number
	typedef logic [$clog2(`SW_NETH)-1:0]	port_idx_t;

	// One stream beat
	typedef logic [`SW_PKTDW-1:0]		beat_t;

	// Ingress head handling
	typedef enum logic [1:0] {
		ST_HEAD,	// Waiting for a head beat
		ST_LEARN,	// Head held, learn and lookup pending
		ST_SEND,	// Forwarding head, then body
		ST_DROP		// Swallowing beats until last
	} ingress_state_t;

endpackage

`default_nettype wire

/* design/route_table.sv */
`timescale 1ns/100ps
`default_nettype none
`include "switch_consts.svh"

module route_table (
	input	wire logic			i_clk,
	input	wire logic			i_reset,
	input	wire switch_pkg::port_mask_t	i_learn_valid,
	output	switch_pkg::port_mask_t		o_learn_ready,
	input	wire switch_pkg::mac_t		i_learn_mac [`SW_NETH],
	input	wire switch_pkg::mac_t		i_lookup_mac [`SW_NETH],
	output	switch_pkg::port_mask_t		o_lookup_hit,
	output	switch_pkg::port_idx_t		o_lookup_port [`SW_NETH]
);
	import switch_pkg::*;

	localparam int	LGTBL = `SW_LGTBL;
	localparam int	NTBL = 1 << LGTBL;

	typedef logic [LGTBL-1:0]	tbl_idx_t;

	// Table entries
	logic	[NTBL-1:0]	tbl_valid;
	mac_t			tbl_mac [NTBL];
	port_idx_t		tbl_port [NTBL];

	// Oldest slot, next to be replaced
	tbl_idx_t		replace_ptr;

	port_idx_t		learn_sel;
	logic			learn_any;
	mac_t			learn_mac;
	logic			learn_hit;
	tbl_idx_t		learn_idx;

	//////////////////////////////
	// Learn arbitration
	//////////////////////////////

	// Lowest requesting port wins, so scan down and keep the last match
	always_comb
	begin
		learn_sel = '0;
		for (int p = `SW_NETH-1; p >= 0; p--)
			if (i_learn_valid[p])
				learn_sel = port_idx_t'(p);
	end

	assign learn_any = |i_learn_valid;
	assign learn_mac = i_learn_mac[learn_sel];

	// One ready per cycle, to the winner only
	always_comb
	begin
		o_learn_ready = '0;
		o_learn_ready[learn_sel] = learn_any;
	end

	// Is this source already known
	always_comb
	begin
		learn_hit = 1'b0;
		learn_idx = '0;
		for (int e = 0; e < NTBL; e++)
			if (tbl_valid[e] && tbl_mac[e] == learn_mac)
			begin
				learn_hit = 1'b1;
				learn_idx = tbl_idx_t'(e);
			end
	end

	//////////////////////////////
	// Table update
	//////////////////////////////

	// New MAC fills the oldest slot and moves the pointer on
	always_ff @(posedge i_clk)
	if (i_reset)
	begin
		tbl_valid <= '0;
		replace_ptr <= '0;
	end else if (learn_any && !learn_hit)
	begin
		tbl_valid[replace_ptr] <= 1'b1;
		replace_ptr <= replace_ptr + 1'b1;
	end

	// Known MAC only moves to its new port
	always_ff @(posedge i_clk)
	if (learn_any)
	begin
		if (learn_hit)
			tbl_port[learn_idx] <= learn_sel;
		else
		begin
			tbl_mac[replace_ptr] <= learn_mac;
			tbl_port[replace_ptr] <= learn_sel;
		end
	end

	//////////////////////////////
	// Parallel lookups
	//////////////////////////////

	// Sees the table as it stood before this cycle's write
	always_comb
	for (int p = 0; p < `SW_NETH; p++)
	begin
		o_lookup_hit[p] = 1'b0;
		o_lookup_port[p] = '0;
		for (int e = 0; e < NTBL; e++)
			if (tbl_valid[e] && tbl_mac[e] == i_lookup_mac[p])
			begin
				o_lookup_hit[p] = 1'b1;
				o_lookup_port[p] = tbl_port[e];
			end
	end

endmodule

`default_nettype wire

/* design/ingress_lookup.sv */
`timescale 1ns/100ps
`default_nettype none
`include "switch_consts.svh"

module ingress_lookup (
	input	wire logic			i_clk,
	input	wire logic			i_reset,
	input	wire switch_pkg::port_idx_t	i_port,
	// Receive stream
	input	wire logic			i_rx_valid,
	output	logic				o_rx_ready,
	input	wire switch_pkg::beat_t		i_rx_data,
	input	wire logic			i_rx_last,
	// Learn request to the table
	output	logic				o_learn_valid,
	input	wire logic			i_learn_ready,
	output	switch_pkg::mac_t		o_learn_mac,
	// Destination lookup
	output	switch_pkg::mac_t		o_lookup_mac,
	input	wire logic			i_lookup_hit,
	input	wire switch_pkg::port_idx_t	i_lookup_port,
	// Stream toward the fanout
	output	logic				o_valid,
	input	wire logic			i_ready,
	output	switch_pkg::beat_t		o_data,
	output	logic				o_last,
	output	switch_pkg::port_mask_t		o_mask
);
	import switch_pkg::*;

	ingress_state_t	state;
	logic		head_held;
	beat_t		head_data;
	logic		head_last;
	port_mask_t	pkt_mask;
	port_mask_t	lookup_mask;
	logic		self_hit;

	// Head layout: dst MAC on top, src MAC right below it
	assign o_lookup_mac = head_data[`SW_PKTDW-1 -: `SW_MACW];
	assign o_learn_mac = head_data[`SW_PKTDW-`SW_MACW-1 -: `SW_MACW];
	assign o_learn_valid = (state == ST_LEARN);
	assign o_mask = pkt_mask;

	//////////////////////////////
	// Destination set
	//////////////////////////////

	// Known MAC goes to one port, unknown floods all others
	always_comb
	if (i_lookup_hit)
		lookup_mask = port_mask_t'(1) << i_lookup_port;
	else
		lookup_mask = ~(port_mask_t'(1) << i_port);

	// Destination lives behind the port it came from
	assign self_hit = i_lookup_hit && (i_lookup_port == i_port);

	//////////////////////////////
	// Stream steering
	//////////////////////////////

	always_comb
	begin
		o_rx_ready = 1'b0;
		o_valid = 1'b0;
		o_data = i_rx_data;
		o_last = i_rx_last;
		case (state)
		ST_HEAD:
			o_rx_ready = 1'b1;
		ST_SEND:
			if (head_held)
			begin
				// Replay the stored head first
				o_valid = 1'b1;
				o_data = head_data;
				o_last = head_last;
			end else
			begin
				// Body passes straight through
				o_valid = i_rx_valid;
				o_rx_ready = i_ready;
			end
		ST_DROP:
			o_rx_ready = 1'b1;
		default:
			o_rx_ready = 1'b0;
		endcase
	end

	// Head store
	always_ff @(posedge i_clk)
	if (state == ST_HEAD && i_rx_valid)
	begin
		head_data <= i_rx_data;
		head_last <= i_rx_last;
	end

	//////////////////////////////
	// Packet FSM
	//////////////////////////////

	always_ff @(posedge i_clk)
	if (i_reset)
	begin
		state <= ST_HEAD;
		head_held <= 1'b0;
		pkt_mask <= '0;
	end else
	case (state)
	ST_HEAD:
		if (i_rx_valid)
		begin
			state <= ST_LEARN;
			head_held <= 1'b1;
		end
	ST_LEARN:
		// Lookup result is taken on the learn accept edge
		if (i_learn_ready)
		begin
			if (self_hit)
			begin
				head_held <= 1'b0;
				state <= head_last ? ST_HEAD : ST_DROP;
			end else
			begin
				pkt_mask <= lookup_mask;
				state <= ST_SEND;
			end
		end
	ST_SEND:
		if (o_valid && i_ready)
		begin
			head_held <= 1'b0;
			if (o_last)
				state <= ST_HEAD;
		end
	ST_DROP:
		if (i_rx_valid && i_rx_last)
			state <= ST_HEAD;
	default:
		state <= ST_HEAD;
	endcase

endmodule

`default_nettype wire

/* design/pkt_fanout.sv */
`timescale 1ns/100ps
`default_nettype none
`include "switch_consts.svh"

module pkt_fanout (
	input	wire logic			i_clk,
	input	wire logic			i_reset,
	// Stream from ingress
	input	wire logic			i_valid,
	output	logic				o_ready,
	input	wire logic			i_last,
	input	wire switch_pkg::port_mask_t	i_mask,
	// One valid/ready pair per output
	output	switch_pkg::port_mask_t		o_valid,
	input	wire switch_pkg::port_mask_t	i_ready
);
	import switch_pkg::*;

	// Outputs that already took the current beat
	port_mask_t	taken;
	// Mask latched at the head, for the body beats
	port_mask_t	pkt_mask;
	port_mask_t	cur_mask;
	logic		in_pkt;

	assign cur_mask = in_pkt ? pkt_mask : i_mask;

	// Offer the beat only where it is still owed
	assign o_valid = {`SW_NETH{i_valid}} & cur_mask & ~taken;

	// Upstream moves once every masked output has the beat
	assign o_ready = &(~cur_mask | taken | i_ready);

	//////////////////////////////
	// Packet tracking
	//////////////////////////////

	always_ff @(posedge i_clk)
	if (i_reset)
		in_pkt <= 1'b0;
	else if (i_valid && o_ready)
		in_pkt <= !i_last;

	always_ff @(posedge i_clk)
	if (i_valid && !in_pkt)
		pkt_mask <= i_mask;

	//////////////////////////////
	// Per-beat delivery record
	//////////////////////////////

	always_ff @(posedge i_clk)
	if (i_reset)
		taken <= '0;
	else if (i_valid && o_ready)
		taken <= '0;
	else
		taken <= taken | (o_valid & i_ready);

endmodule

`default_nettype wire

/* design/tx_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none
`include "switch_consts.svh"

module tx_arbiter (
	input	wire logic			i_clk,
	input	wire logic			i_reset,
	// Requests from every fanout
	input	wire switch_pkg::port_mask_t	i_valid,
	output	switch_pkg::port_mask_t		o_ready,
	input	wire switch_pkg::beat_t		i_data [`SW_NETH],
	input	wire switch_pkg::port_mask_t	i_last,
	// Transmit port
	output	logic				o_tx_valid,
	input	wire logic			i_tx_ready,
	output	switch_pkg::beat_t		o_tx_data,
	output	logic				o_tx_last
);
	import switch_pkg::*;

	// Current owner, and last winner while idle
	port_idx_t	grant;
	logic		busy;
	port_idx_t	pick;
	logic		pick_any;

	//////////////////////////////
	// Round-robin choice
	//////////////////////////////

	// Nearest requester after the last winner, which itself comes last
	always_comb
	begin
		pick_any = |i_valid;
		pick = grant;
		for (int k = `SW_NETH; k >= 1; k--)
			if (i_valid[(int'(grant) + k) % `SW_NETH])
				pick = port_idx_t'((int'(grant) + k) % `SW_NETH);
	end

	// Grant is held for a whole packet
	always_ff @(posedge i_clk)
	if (i_reset)
	begin
		busy <= 1'b0;
		grant <= port_idx_t'(`SW_NETH-1);
	end else if (!busy)
	begin
		if (pick_any)
		begin
			busy <= 1'b1;
			grant <= pick;
		end
	end else if (o_tx_valid && i_tx_ready && o_tx_last)
		busy <= 1'b0;

	//////////////////////////////
	// Granted path
	//////////////////////////////

	assign o_tx_valid = busy && i_valid[grant];
	assign o_tx_data = i_data[grant];
	assign o_tx_last = i_last[grant];

	// Back-pressure only reaches the owner
	always_comb
	begin
		o_ready = '0;
		o_ready[grant] = busy && i_tx_ready;
	end

endmodule

`default_nettype wire

/* design/switch_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "switch_consts.svh"

module switch_top (
	input	wire logic			i_clk,
	input	wire logic			i_reset,
	// Receive side, one stream per port
	input	wire switch_pkg::port_mask_t	i_rx_valid,
	output	switch_pkg::port_mask_t		o_rx_ready,
	input	wire switch_pkg::beat_t		i_rx_data [`SW_NETH],
	input	wire switch_pkg::port_mask_t	i_rx_last,
	// Transmit side, one stream per port
	output	switch_pkg::port_mask_t		o_tx_valid,
	input	wire switch_pkg::port_mask_t	i_tx_ready,
	output	switch_pkg::beat_t		o_tx_data [`SW_NETH],
	output	switch_pkg::port_mask_t		o_tx_last
);
	import switch_pkg::*;

	// Table traffic
	port_mask_t	learn_valid, learn_ready;
	mac_t		learn_mac [`SW_NETH];
	mac_t		lookup_mac [`SW_NETH];
	port_mask_t	lookup_hit;
	port_idx_t	lookup_port [`SW_NETH];

	// Ingress streams, shared by every arbiter
	port_mask_t	ing_valid, ing_ready, ing_last;
	beat_t		ing_data [`SW_NETH];
	port_mask_t	ing_mask [`SW_NETH];

	// Crossbar, fanout side indexed [src][dst]
	port_mask_t	fan_valid [`SW_NETH];
	port_mask_t	fan_ready [`SW_NETH];
	// Crossbar, arbiter side indexed [dst][src]
	port_mask_t	arb_valid [`SW_NETH];
	port_mask_t	arb_ready [`SW_NETH];

	genvar		gp, gq;

	route_table u_route_table (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_learn_valid(learn_valid), .o_learn_ready(learn_ready),
		.i_learn_mac(learn_mac),
		.i_lookup_mac(lookup_mac),
		.o_lookup_hit(lookup_hit), .o_lookup_port(lookup_port)
	);

	//////////////////////////////
	// Per-port blocks
	//////////////////////////////

	generate
	for (gp = 0; gp < `SW_NETH; gp++)
	begin : g_port
		ingress_lookup u_ingress (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_port(port_idx_t'(gp)),
			.i_rx_valid(i_rx_valid[gp]), .o_rx_ready(o_rx_ready[gp]),
			.i_rx_data(i_rx_data[gp]), .i_rx_last(i_rx_last[gp]),
			.o_learn_valid(learn_valid[gp]), .i_learn_ready(learn_ready[gp]),
			.o_learn_mac(learn_mac[gp]),
			.o_lookup_mac(lookup_mac[gp]),
			.i_lookup_hit(lookup_hit[gp]), .i_lookup_port(lookup_port[gp]),
			.o_valid(ing_valid[gp]), .i_ready(ing_ready[gp]),
			.o_data(ing_data[gp]), .o_last(ing_last[gp]),
			.o_mask(ing_mask[gp])
		);

		pkt_fanout u_fanout (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_valid(ing_valid[gp]), .o_ready(ing_ready[gp]),
			.i_last(ing_last[gp]), .i_mask(ing_mask[gp]),
			.o_valid(fan_valid[gp]), .i_ready(fan_ready[gp])
		);

		// Output gp sees data and last of every source directly
		tx_arbiter u_arbiter (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_valid(arb_valid[gp]), .o_ready(arb_ready[gp]),
			.i_data(ing_data), .i_last(ing_last),
			.o_tx_valid(o_tx_valid[gp]), .i_tx_ready(i_tx_ready[gp]),
			.o_tx_data(o_tx_data[gp]), .o_tx_last(o_tx_last[gp])
		);

		// Transpose between fanout and arbiter views
		for (gq = 0; gq < `SW_NETH; gq++)
		begin : g_xbar
			assign arb_valid[gp][gq] = fan_valid[gq][gp];
			assign fan_ready[gp][gq] = arb_ready[gq][gp];
		end
	end
	endgenerate

endmodule

`default_nettype wire

/* test/switch_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "switch_consts.svh"

module switch_tb;
	import switch_pkg::*;

	localparam int	NETH = `SW_NETH;
	localparam int	PKTDW = `SW_PKTDW;
	localparam int	TBL_N = 1 << `SW_LGTBL;
	localparam int	CLK_PERIOD = 4;
	localparam int	MAX_BEATS = 4;
	localparam int	QDEPTH = 512;
	localparam int	DRAIN_CYCLES = 400;
	// Packets sent one at a time, then per port in the concurrent test
	localparam int	SEQ_PKTS = 28;
	localparam int	CONC_PKTS = 30;
	localparam int	TOTAL_BEATS = (SEQ_PKTS + CONC_PKTS * NETH) * MAX_BEATS;
	localparam int	WATCHDOG_NS = 20 * TOTAL_BEATS * CLK_PERIOD;

	logic		i_clk;
	logic		i_reset;
	port_mask_t	i_rx_valid;
	port_mask_t	o_rx_ready;
	beat_t		i_rx_data [NETH];
	port_mask_t	i_rx_last;
	port_mask_t	o_tx_valid;
	port_mask_t	i_tx_ready;
	beat_t		o_tx_data [NETH];
	port_mask_t	o_tx_last;

	int		seed;
	int		seq_no;
	logic		rand_ready;

	// Reference copy of the MAC table
	logic		model_valid [TBL_N];
	mac_t		model_mac [TBL_N];
	int		model_port [TBL_N];
	int		model_ptr;

	// Expected beats, {last, data}, one ring per output and source
	logic [PKTDW:0]	exp_mem [NETH*NETH][QDEPTH];
	int		wr_ptr [NETH*NETH];
	int		rd_ptr [NETH*NETH];

	// Monitor state per output
	port_mask_t	mon_busy;
	int		mon_src [NETH];

	switch_top switch_top_i (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_rx_valid(i_rx_valid), .o_rx_ready(o_rx_ready),
		.i_rx_data(i_rx_data), .i_rx_last(i_rx_last),
		.o_tx_valid(o_tx_valid), .i_tx_ready(i_tx_ready),
		.o_tx_data(o_tx_data), .o_tx_last(o_tx_last)
	);

	always
		#(CLK_PERIOD/2) i_clk = ~i_clk;

	//////////////////////////////
	// Error handling
	//////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0d ns: %s is %0h, expected %0h",
				$time, name, got, exp));
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic mac_t mac_of(input int k);
		return {16'h0200, 32'(k)};
	endfunction

	// Addresses that the concurrent test learns up front, two per port
	function automatic mac_t learned_mac(input int k);
		return mac_of(32'h100 + k);
	endfunction

	// Hit on another port goes there, hit on own port drops, miss floods
	function automatic port_mask_t expected_mask(input mac_t dst, input int port);
		port_mask_t m;
		m = ~(port_mask_t'(1) << port);
		for (int e = 0; e < TBL_N; e++)
			if (model_valid[e] && model_mac[e] == dst)
			begin
				if (model_port[e] == port)
					m = '0;
				else
					m = port_mask_t'(1) << model_port[e];
			end
		return m;
	endfunction

	// Known MAC moves in place, a new one takes the oldest slot
	function automatic void learn_model(input mac_t mac, input int port);
		int hit_idx;
		hit_idx = -1;
		for (int e = 0; e < TBL_N; e++)
			if (model_valid[e] && model_mac[e] == mac)
				hit_idx = e;
		if (hit_idx >= 0)
			model_port[hit_idx] = port;
		else
		begin
			model_valid[model_ptr] = 1'b1;
			model_mac[model_ptr] = mac;
			model_port[model_ptr] = port;
			model_ptr = (model_ptr + 1) % TBL_N;
		end
	endfunction

	task automatic push_expected(input int k, input logic [PKTDW:0] value);
		if (wr_ptr[k] - rd_ptr[k] >= QDEPTH)
			fail_run("Expected-beat storage overflowed, outputs are not draining");
		exp_mem[k][wr_ptr[k] % QDEPTH] = value;
		wr_ptr[k]++;
	endtask

	function automatic int pending_beats();
		int n;
		n = 0;
		for (int k = 0; k < NETH*NETH; k++)
			n += wr_ptr[k] - rd_ptr[k];
		return n;
	endfunction

	task automatic report_missing();
		for (int k = 0; k < NETH*NETH; k++)
			if (wr_ptr[k] != rd_ptr[k])
				$display("Output %0d is missing %0d beats from port %0d",
					k / NETH, wr_ptr[k] - rd_ptr[k], k % NETH);
		fail_run("Expected packets never arrived on the tx ports");
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic apply_reset();
		@(negedge i_clk);
		i_reset = 1'b1;
		repeat (3) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b0;
		mon_busy = '0;
		model_ptr = 0;
		for (int e = 0; e < TBL_N; e++)
			model_valid[e] = 1'b0;
	endtask

	task automatic random_beat(output beat_t b);
		for (int i = 0; i < PKTDW / 32; i++)
			b[i*32 +: 32] = $random(seed);
	endtask

	// Model first, then drive the beats onto the rx port
	task automatic send_packet(input int port, input mac_t dst, input mac_t src,
		input int nbeats, output port_mask_t mask);
		beat_t		beats [MAX_BEATS];
		logic [PKTDW-2*`SW_MACW-1:0] tag;
		tag = {24'(seq_no), 8'(port)};
		seq_no++;
		mask = expected_mask(dst, port);
		learn_model(src, port);
		beats[0] = {dst, src, tag};
		for (int b = 1; b < nbeats; b++)
			random_beat(beats[b]);
		for (int q = 0; q < NETH; q++)
			if (mask[q])
				for (int b = 0; b < nbeats; b++)
					push_expected(q*NETH + port, {b == nbeats-1, beats[b]});
		for (int b = 0; b < nbeats; b++)
		begin
			@(negedge i_clk);
			i_rx_valid[port] = 1'b1;
			i_rx_data[port] = beats[b];
			i_rx_last[port] = (b == nbeats-1);
			@(posedge i_clk);
			while (!o_rx_ready[port])
				@(posedge i_clk);
		end
		@(negedge i_clk);
		i_rx_valid[port] = 1'b0;
		i_rx_last[port] = 1'b0;
	endtask

	// Bounded wait for every expected beat to show up
	task automatic settle();
		for (int c = 0; c < DRAIN_CYCLES && pending_beats() != 0; c++)
			@(posedge i_clk);
	endtask

	task automatic drain();
		settle();
		if (pending_beats() != 0)
			report_missing();
	endtask

	task automatic port_traffic(input int port);
		port_mask_t	m;
		int		ssel;
		int		dsel;
		int		nbeats;
		for (int n = 0; n < CONC_PKTS; n++)
		begin
			// Source stays on its own port, destination always known
			ssel = port + NETH * ($unsigned($random(seed)) % 2);
			dsel = $unsigned($random(seed)) % (2*NETH);
			nbeats = 1 + $unsigned($random(seed)) % MAX_BEATS;
			send_packet(port, learned_mac(dsel), learned_mac(ssel), nbeats, m);
			repeat ($unsigned($random(seed)) % 3)
				@(negedge i_clk);
		end
	endtask

	// Random tx back-pressure, per port
	always @(negedge i_clk)
		for (int q = 0; q < NETH; q++)
			i_tx_ready[q] = rand_ready ? (($unsigned($random(seed)) % 3) != 0) : 1'b1;

	//////////////////////////////
	// Monitor
	//////////////////////////////

	// Head tag names the source, body beats follow the current owner
	task automatic take_beat(input int q);
		int		s;
		int		k;
		logic [PKTDW:0]	exp;
		if (mon_busy[q])
			s = mon_src[q];
		else
			s = int'(o_tx_data[q][7:0]);
		if (s >= NETH)
			fail_run($sformatf("Output %0d sent a head with a bad source tag %0d", q, s));
		k = q*NETH + s;
		if (rd_ptr[k] == wr_ptr[k])
			fail_run($sformatf("Output %0d sent a beat that no packet from port %0d owes",
				q, s));
		exp = exp_mem[k][rd_ptr[k] % QDEPTH];
		rd_ptr[k]++;
		check_value($sformatf("o_tx_data[%0d]", q), o_tx_data[q], exp[PKTDW-1:0]);
		check_value($sformatf("o_tx_last[%0d]", q), o_tx_last[q], exp[PKTDW]);
		mon_busy[q] = !o_tx_last[q];
		mon_src[q] = s;
	endtask

	always @(posedge i_clk)
		if (!i_reset)
			for (int q = 0; q < NETH; q++)
				if (o_tx_valid[q] && i_tx_ready[q])
					take_beat(q);

	initial
	begin
		#(WATCHDOG_NS);
		fail_run($sformatf("Watchdog expired after %0d ns with packets still in flight",
			WATCHDOG_NS));
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		port_mask_t	m;
		seed = 32'ha661;
		seq_no = 0;
		rand_ready = 1'b0;
		i_clk = 1'b0;
		i_reset = 1'b1;
		i_rx_valid = '0;
		i_rx_last = '0;
		i_tx_ready = '1;
		mon_busy = '0;
		for (int p = 0; p < NETH; p++)
			i_rx_data[p] = '0;
		apply_reset();

		// Unknown destination floods everywhere but the source
		send_packet(0, mac_of(32'hffff0000), mac_of(32'h10), 3, m);
		check_value("flood mask", m, port_mask_t'(~(port_mask_t'(1))));
		drain();

		// Learned destination goes to one port only
		send_packet(2, mac_of(32'hffff0001), mac_of(32'ha), 2, m);
		drain();
		send_packet(0, mac_of(32'ha), mac_of(32'h10), 4, m);
		check_value("learned mask", m, port_mask_t'(1) << 2);
		drain();

		// Destination behind its own port is dropped, next packet still passes
		send_packet(1, mac_of(32'hffff0002), mac_of(32'hb), 1, m);
		drain();
		send_packet(1, mac_of(32'hb), mac_of(32'hb), 3, m);
		check_value("drop mask", m, '0);
		drain();
		send_packet(1, mac_of(32'ha), mac_of(32'hb), 2, m);
		check_value("after drop mask", m, port_mask_t'(1) << 2);
		drain();

		// Nine sources into eight slots evict the first
		apply_reset();
		for (int k = 1; k <= 9; k++)
		begin
			send_packet(k % NETH, mac_of(32'hffff0003), mac_of(32'h200 + k), 1, m);
			drain();
		end
		send_packet(8 % NETH, mac_of(32'h201), mac_of(32'h208), 2, m);
		check_value("evicted mask", m, port_mask_t'(~(port_mask_t'(1) << (8 % NETH))));
		drain();
		send_packet(6 % NETH, mac_of(32'h209), mac_of(32'h206), 2, m);
		check_value("newest mask", m, port_mask_t'(1) << (9 % NETH));
		drain();

		// Fill the table, then all ports at once under back-pressure
		apply_reset();
		for (int k = 0; k < 2*NETH; k++)
		begin
			send_packet(k % NETH, mac_of(32'hffff0004), learned_mac(k), 1, m);
			drain();
		end
		rand_ready = 1'b1;
		for (int p = 0; p < NETH; p++)
		begin
			automatic int pp = p;
			fork
				port_traffic(pp);
			join_none
		end
		wait fork;
		drain();

		// Long floods with each output stalling on its own
		for (int p = 0; p < 3; p++)
		begin
			send_packet(p, mac_of(32'hffff0005), learned_mac(p), MAX_BEATS, m);
			check_value("long flood mask", m, port_mask_t'(~(port_mask_t'(1) << p)));
			drain();
		end

		settle();
		if (pending_beats() == 0)
		begin
			$display("TEST OK");
			$finish;
		end else
			report_missing();
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+design
design/switch_pkg.sv
design/route_table.sv
design/ingress_lookup.sv
design/pkt_fanout.sv
design/tx_arbiter.sv
design/switch_top.sv
test/switch_tb.sv
